//--- logic/gsm_pkg.sv
// gsm memory unit shared definitions
// sizes, config register codes and emit scheduler states
`default_nettype none

package gsm_pkg;

	// -------------------------------------------------------------------------
	// sizes
	// -------------------------------------------------------------------------

	// switch ports, one ingress and one egress each
	localparam int NPORTS = 4;
	localparam int LOG_NPORTS = 2;

	// cell payload, 16 bytes
	localparam int DWIDTH = 128;

	// private region of 128 cells per ingress port
	localparam int AWIDTH = 7;

	// central ram address, source port in the upper bits
	localparam int RAM_AWIDTH = AWIDTH + LOG_NPORTS;

	// config bus data and almost-full threshold widths
	localparam int CFG_DWIDTH = 8;
	localparam int AF_WIDTH = 5;

	// -------------------------------------------------------------------------
	// encodings
	// -------------------------------------------------------------------------

	// config register select
	typedef enum logic [1:0] {
		CFG_EGRESS_EN = 2'd0,
		CFG_AF_THRESH = 2'd1
	} cfg_reg_e;

	// multicast emit scheduler
	typedef enum logic [1:0] {
		EMIT_IDLE = 2'd0,
		EMIT_READ = 2'd1,
		EMIT_WAIT = 2'd2,
		EMIT_SEND = 2'd3
	} emit_state_e;

endpackage

`default_nettype wire

//--- logic/gsm_sync_fifo.sv
// synchronous first-word-fall-through fifo
// drops pushes when full, ignores pops when empty
`default_nettype none

module gsm_sync_fifo #(
	parameter int DATA_W = 8,
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                clk_320M,
	input  logic                rst_n,
	input  logic                i_push,
	input  logic [DATA_W-1:0]   i_push_data,
	input  logic                i_pop,
	input  logic [DEPTH_LOG2:0] i_af_thresh,
	output logic [DATA_W-1:0]   o_head,
	output logic                o_empty,
	output logic                o_full,
	output logic                o_almost_full
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	logic [DATA_W-1:0]   mem [DEPTH];
	// one extra bit tells full from empty
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;
	logic [DEPTH_LOG2:0] count;
	logic                do_push;
	logic                do_pop;

	assign count = wr_ptr - rd_ptr;
	assign o_empty = (count == '0);
	// msb of count only set at DEPTH
	assign o_full = count[DEPTH_LOG2];
	assign o_almost_full = (count >= i_af_thresh);

	assign do_push = i_push & ~o_full;
	assign do_pop = i_pop & ~o_empty;

	// head shows through without a read cycle
	assign o_head = mem[rd_ptr[DEPTH_LOG2-1:0]];

	always_ff @(posedge clk_320M or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk_320M) begin
		if (do_push)
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_push_data;
	end

endmodule

`default_nettype wire

//--- logic/gsm_ingress_mux.sv
// ingress command mux
// registers the write command of the port that owns the common bus
`default_nettype none

module gsm_ingress_mux
	import gsm_pkg::*;
#(
	parameter int DATA_W = DWIDTH,
	parameter int CELL_AW = AWIDTH
) (
	input  logic                         clk_320M,
	input  logic                         rst_n,
	// per-port write commands
	input  logic                         i_wr_en0,
	input  logic [CELL_AW-1:0]           i_wr_addr0,
	input  logic [NPORTS-1:0]            i_multicast0,
	input  logic                         i_wr_en1,
	input  logic [CELL_AW-1:0]           i_wr_addr1,
	input  logic [NPORTS-1:0]            i_multicast1,
	input  logic                         i_wr_en2,
	input  logic [CELL_AW-1:0]           i_wr_addr2,
	input  logic [NPORTS-1:0]            i_multicast2,
	input  logic                         i_wr_en3,
	input  logic [CELL_AW-1:0]           i_wr_addr3,
	input  logic [NPORTS-1:0]            i_multicast3,
	// common data bus
	input  logic [NPORTS-1:0]            i_common_sel,
	input  logic [DATA_W-1:0]            i_common_wr_data,
	// tagged command towards the ram
	output logic                         o_wr_en,
	output logic [CELL_AW+LOG_NPORTS-1:0] o_wr_addr,
	output logic [NPORTS-1:0]            o_multicast,
	output logic [DATA_W-1:0]            o_wr_data
);

	logic [NPORTS-1:0]     wr_en_vec;
	logic [CELL_AW-1:0]    wr_addr_arr [NPORTS];
	logic [NPORTS-1:0]     mcast_arr [NPORTS];
	logic                  sel_valid;
	logic [LOG_NPORTS-1:0] sel_port;

	// gather the loose port triples
	assign wr_en_vec = {i_wr_en3, i_wr_en2, i_wr_en1, i_wr_en0};
	assign wr_addr_arr[0] = i_wr_addr0;
	assign wr_addr_arr[1] = i_wr_addr1;
	assign wr_addr_arr[2] = i_wr_addr2;
	assign wr_addr_arr[3] = i_wr_addr3;
	assign mcast_arr[0] = i_multicast0;
	assign mcast_arr[1] = i_multicast1;
	assign mcast_arr[2] = i_multicast2;
	assign mcast_arr[3] = i_multicast3;

	// zero or multi-bit select is no owner
	assign sel_valid = $onehot(i_common_sel);

	// one-hot to port number
	always_comb begin
		sel_port = '0;
		for (int k = 0; k < NPORTS; k++) begin
			if (i_common_sel[k])
				sel_port = LOG_NPORTS'(k);
		end
	end

	// command register, port number tags the ram address
	always_ff @(posedge clk_320M or negedge rst_n) begin
		if (!rst_n) begin
			o_wr_en <= 1'b0;
			o_wr_addr <= '0;
			o_multicast <= '0;
		end else begin
			o_wr_en <= sel_valid & wr_en_vec[sel_port];
			o_wr_addr <= {sel_port, wr_addr_arr[sel_port]};
			o_multicast <= mcast_arr[sel_port];
		end
	end

	// payload stage, keeps data aligned with its command
	always_ff @(posedge clk_320M) begin
		o_wr_data <= i_common_wr_data;
	end

endmodule

`default_nettype wire

//--- logic/gsm_cfg_regs.sv
// memory unit config registers
// egress enable mask and egress almost-full threshold
`default_nettype none

module gsm_cfg_regs
	import gsm_pkg::*;
(
	input  logic                  clk_320M,
	input  logic                  rst_n,
	// single-cycle write strobe
	input  logic                  i_cfg_wr,
	input  cfg_reg_e              i_cfg_addr,
	input  logic [CFG_DWIDTH-1:0] i_cfg_wdata,
	// register values
	output logic [NPORTS-1:0]     o_egress_en,
	output logic [AF_WIDTH-1:0]   o_af_thresh
);

	// all egress ports on, threshold at three quarters of 16 entries
	localparam logic [AF_WIDTH-1:0] AF_THRESH_RST = AF_WIDTH'(12);

	always_ff @(posedge clk_320M or negedge rst_n) begin
		if (!rst_n) begin
			o_egress_en <= '1;
			o_af_thresh <= AF_THRESH_RST;
		end else if (i_cfg_wr) begin
			case (i_cfg_addr)
				CFG_EGRESS_EN: begin
					o_egress_en <= i_cfg_wdata[NPORTS-1:0];
				end
				CFG_AF_THRESH: begin
					o_af_thresh <= i_cfg_wdata[AF_WIDTH-1:0];
				end
				// unknown codes, nothing changes
				default: begin
					o_egress_en <= o_egress_en;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/gsm_central_ram.sv
// central shared cell memory
// queues written cells, emits them to egress targets and frees the address
`default_nettype none

module gsm_central_ram
	import gsm_pkg::*;
#(
	parameter int DATA_W = DWIDTH,
	parameter int CELL_AW = AWIDTH,
	parameter int PENDING_LOG2 = 4
) (
	input  logic                          clk_320M,
	input  logic                          rst_n,
	// write side, from the ingress mux
	input  logic                          i_wr_en,
	input  logic [CELL_AW+LOG_NPORTS-1:0] i_wr_addr,
	input  logic [NPORTS-1:0]             i_multicast,
	input  logic [DATA_W-1:0]             i_wr_data,
	// egress control
	input  logic [NPORTS-1:0]             i_egress_en,
	input  logic [NPORTS-1:0]             i_egress_stall,
	output logic [NPORTS-1:0]             o_egress_sel,
	output logic [DATA_W-1:0]             o_egress_data,
	// address return
	output logic                          o_buf_free,
	output logic [LOG_NPORTS-1:0]         o_buf_free_port,
	output logic [CELL_AW-1:0]            o_buf_free_addr
);

	localparam int RAM_AW = CELL_AW + LOG_NPORTS;
	localparam int RAM_DEPTH = 2 ** RAM_AW;

	// -------------------------------------------------------------------------
	// cell storage
	// -------------------------------------------------------------------------

	logic [DATA_W-1:0] cell_mem [RAM_DEPTH];
	logic [NPORTS-1:0] mcast_mem [RAM_DEPTH];
	logic [DATA_W-1:0] rd_data;

	emit_state_e       state;
	logic [RAM_AW-1:0] pend_head;
	logic              pend_empty;
	logic              pend_pop;
	logic [RAM_AW-1:0] cur_addr;
	logic [NPORTS-1:0] cur_mcast;
	logic [NPORTS-1:0] targets;
	logic [NPORTS-1:0] send_sel;

	// payload and multicast vector per cell
	always_ff @(posedge clk_320M) begin
		if (i_wr_en) begin
			cell_mem[i_wr_addr] <= i_wr_data;
			mcast_mem[i_wr_addr] <= i_multicast;
		end
		// fetch at the pending head
		if (state == EMIT_READ)
			rd_data <= cell_mem[pend_head];
	end

	// -------------------------------------------------------------------------
	// pending queue, write order of cells
	// -------------------------------------------------------------------------

	// pushed with the ram write, popped when the cell is fetched
	assign pend_pop = (state == EMIT_READ);

	gsm_sync_fifo #(
		.DATA_W     (RAM_AW),
		.DEPTH_LOG2 (PENDING_LOG2)
	) pending_q (
		.clk_320M      (clk_320M),
		.rst_n         (rst_n),
		.i_push        (i_wr_en),
		.i_push_data   (i_wr_addr),
		.i_pop         (pend_pop),
		.i_af_thresh   ({1'b1, {PENDING_LOG2{1'b0}}}),
		.o_head        (pend_head),
		.o_empty       (pend_empty),
		.o_full        (),
		.o_almost_full ()
	);

	// -------------------------------------------------------------------------
	// emit scheduler
	// -------------------------------------------------------------------------

	// disabled ports never get the cell
	assign targets = cur_mcast & i_egress_en;

	always_ff @(posedge clk_320M or negedge rst_n) begin
		if (!rst_n) begin
			state <= EMIT_IDLE;
			cur_addr <= '0;
			cur_mcast <= '0;
			send_sel <= '0;
		end else begin
			case (state)
				EMIT_IDLE: begin
					if (!pend_empty)
						state <= EMIT_READ;
				end
				EMIT_READ: begin
					cur_addr <= pend_head;
					cur_mcast <= mcast_mem[pend_head];
					state <= EMIT_WAIT;
				end
				EMIT_WAIT: begin
					// hold while any target is almost full
					if ((targets & i_egress_stall) == '0) begin
						send_sel <= targets;
						state <= EMIT_SEND;
					end
				end
				EMIT_SEND: begin
					state <= EMIT_IDLE;
				end
				default: begin
					state <= EMIT_IDLE;
				end
			endcase
		end
	end

	// broadcast, one push per target in the same cycle
	assign o_egress_sel = (state == EMIT_SEND) ? send_sel : '0;
	assign o_egress_data = rd_data;

	// freed even with an empty target set
	assign o_buf_free = (state == EMIT_SEND);
	assign o_buf_free_port = cur_addr[RAM_AW-1 -: LOG_NPORTS];
	assign o_buf_free_addr = cur_addr[CELL_AW-1:0];

endmodule

`default_nettype wire

//--- logic/gsm_unit.sv
// grouped shared-memory switch memory unit
// ingress mux, config, central ram, egress and buffer-free fifos
`default_nettype none

module gsm_unit
	import gsm_pkg::*;
#(
	parameter int DATA_W = DWIDTH,
	parameter int CELL_AW = AWIDTH,
	parameter int FIFO_LOG2 = 4,
	parameter int PENDING_LOG2 = 4
) (
	input  logic                  clk_320M,
	input  logic                  rst_n,
	// ingress write commands
	input  logic                  i_wr_en0,
	input  logic [CELL_AW-1:0]    i_wr_addr0,
	input  logic [NPORTS-1:0]     i_multicast0,
	input  logic                  i_wr_en1,
	input  logic [CELL_AW-1:0]    i_wr_addr1,
	input  logic [NPORTS-1:0]     i_multicast1,
	input  logic                  i_wr_en2,
	input  logic [CELL_AW-1:0]    i_wr_addr2,
	input  logic [NPORTS-1:0]     i_multicast2,
	input  logic                  i_wr_en3,
	input  logic [CELL_AW-1:0]    i_wr_addr3,
	input  logic [NPORTS-1:0]     i_multicast3,
	// egress ports
	input  logic                  i_egress_rd0,
	output logic                  o_egress_valid0,
	output logic [DATA_W-1:0]     o_egress_data0,
	input  logic                  i_egress_rd1,
	output logic                  o_egress_valid1,
	output logic [DATA_W-1:0]     o_egress_data1,
	input  logic                  i_egress_rd2,
	output logic                  o_egress_valid2,
	output logic [DATA_W-1:0]     o_egress_data2,
	input  logic                  i_egress_rd3,
	output logic                  o_egress_valid3,
	output logic [DATA_W-1:0]     o_egress_data3,
	// buffer free
	output logic                  o_buf_free0,
	output logic [CELL_AW-1:0]    o_buf_free_addr0,
	output logic                  o_buf_free1,
	output logic [CELL_AW-1:0]    o_buf_free_addr1,
	output logic                  o_buf_free2,
	output logic [CELL_AW-1:0]    o_buf_free_addr2,
	output logic                  o_buf_free3,
	output logic [CELL_AW-1:0]    o_buf_free_addr3,
	// common data bus
	input  logic [NPORTS-1:0]     i_common_sel,
	input  logic [DATA_W-1:0]     i_common_wr_data,
	// config writes
	input  logic                  i_cfg_wr,
	input  cfg_reg_e              i_cfg_addr,
	input  logic [CFG_DWIDTH-1:0] i_cfg_wdata
);

	logic                          ram_wr_en;
	logic [CELL_AW+LOG_NPORTS-1:0] ram_wr_addr;
	logic [NPORTS-1:0]             ram_multicast;
	logic [DATA_W-1:0]             ram_wr_data;
	logic [NPORTS-1:0]             egress_en;
	logic [AF_WIDTH-1:0]           af_thresh;
	logic [NPORTS-1:0]             egress_sel;
	logic [DATA_W-1:0]             egress_wr_data;
	logic [NPORTS-1:0]             egress_rd;
	logic [NPORTS-1:0]             egress_empty;
	logic [NPORTS-1:0]             egress_af;
	logic [DATA_W-1:0]             egress_head [NPORTS];
	logic                          ram_free;
	logic [LOG_NPORTS-1:0]         ram_free_port;
	logic [CELL_AW-1:0]            ram_free_addr;
	logic [NPORTS-1:0]             free_push;
	logic [NPORTS-1:0]             free_empty;
	logic [CELL_AW-1:0]            free_head [NPORTS];

	gsm_ingress_mux #(
		.DATA_W  (DATA_W),
		.CELL_AW (CELL_AW)
	) ingress_mux (
		.clk_320M         (clk_320M),
		.rst_n            (rst_n),
		.i_wr_en0         (i_wr_en0),
		.i_wr_addr0       (i_wr_addr0),
		.i_multicast0     (i_multicast0),
		.i_wr_en1         (i_wr_en1),
		.i_wr_addr1       (i_wr_addr1),
		.i_multicast1     (i_multicast1),
		.i_wr_en2         (i_wr_en2),
		.i_wr_addr2       (i_wr_addr2),
		.i_multicast2     (i_multicast2),
		.i_wr_en3         (i_wr_en3),
		.i_wr_addr3       (i_wr_addr3),
		.i_multicast3     (i_multicast3),
		.i_common_sel     (i_common_sel),
		.i_common_wr_data (i_common_wr_data),
		.o_wr_en          (ram_wr_en),
		.o_wr_addr        (ram_wr_addr),
		.o_multicast      (ram_multicast),
		.o_wr_data        (ram_wr_data)
	);

	gsm_cfg_regs cfg_regs (
		.clk_320M    (clk_320M),
		.rst_n       (rst_n),
		.i_cfg_wr    (i_cfg_wr),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_egress_en (egress_en),
		.o_af_thresh (af_thresh)
	);

	// egress almost-full comes back as stall
	gsm_central_ram #(
		.DATA_W       (DATA_W),
		.CELL_AW      (CELL_AW),
		.PENDING_LOG2 (PENDING_LOG2)
	) central_ram (
		.clk_320M        (clk_320M),
		.rst_n           (rst_n),
		.i_wr_en         (ram_wr_en),
		.i_wr_addr       (ram_wr_addr),
		.i_multicast     (ram_multicast),
		.i_wr_data       (ram_wr_data),
		.i_egress_en     (egress_en),
		.i_egress_stall  (egress_af),
		.o_egress_sel    (egress_sel),
		.o_egress_data   (egress_wr_data),
		.o_buf_free      (ram_free),
		.o_buf_free_port (ram_free_port),
		.o_buf_free_addr (ram_free_addr)
	);

	// -------------------------------------------------------------------------
	// egress and free fifos, one pair per port
	// -------------------------------------------------------------------------

	assign egress_rd = {i_egress_rd3, i_egress_rd2, i_egress_rd1, i_egress_rd0};

	for (genvar g = 0; g < NPORTS; g++) begin : g_port
		gsm_sync_fifo #(
			.DATA_W     (DATA_W),
			.DEPTH_LOG2 (FIFO_LOG2)
		) egress_fifo (
			.clk_320M      (clk_320M),
			.rst_n         (rst_n),
			.i_push        (egress_sel[g]),
			.i_push_data   (egress_wr_data),
			.i_pop         (egress_rd[g]),
			.i_af_thresh   (af_thresh),
			.o_head        (egress_head[g]),
			.o_empty       (egress_empty[g]),
			.o_full        (),
			.o_almost_full (egress_af[g])
		);

		// route the freed address to its source port
		assign free_push[g] = ram_free & (ram_free_port == LOG_NPORTS'(g));

		// drains itself, one address per cycle
		gsm_sync_fifo #(
			.DATA_W     (CELL_AW),
			.DEPTH_LOG2 (FIFO_LOG2)
		) free_fifo (
			.clk_320M      (clk_320M),
			.rst_n         (rst_n),
			.i_push        (free_push[g]),
			.i_push_data   (ram_free_addr),
			.i_pop         (~free_empty[g]),
			.i_af_thresh   (af_thresh),
			.o_head        (free_head[g]),
			.o_empty       (free_empty[g]),
			.o_full        (),
			.o_almost_full ()
		);
	end

	assign o_egress_valid0 = ~egress_empty[0];
	assign o_egress_valid1 = ~egress_empty[1];
	assign o_egress_valid2 = ~egress_empty[2];
	assign o_egress_valid3 = ~egress_empty[3];
	assign o_egress_data0 = egress_head[0];
	assign o_egress_data1 = egress_head[1];
	assign o_egress_data2 = egress_head[2];
	assign o_egress_data3 = egress_head[3];

	assign o_buf_free0 = ~free_empty[0];
	assign o_buf_free1 = ~free_empty[1];
	assign o_buf_free2 = ~free_empty[2];
	assign o_buf_free3 = ~free_empty[3];
	assign o_buf_free_addr0 = free_head[0];
	assign o_buf_free_addr1 = free_head[1];
	assign o_buf_free_addr2 = free_head[2];
	assign o_buf_free_addr3 = free_head[3];

endmodule

`default_nettype wire

//--- tests/gsm_unit_checker.sv
// memory unit protocol checks
// reset quiet outputs, single-cycle free pulses, held egress valid
`default_nettype none

module gsm_unit_checker
	import gsm_pkg::*;
(
	input  logic              clk_320M,
	input  logic              rst_n,
	input  logic [NPORTS-1:0] i_valid,
	input  logic [NPORTS-1:0] i_rd,
	input  logic [NPORTS-1:0] i_free
);

	// no egress word and no free pulse while in reset
	assert property (@(posedge clk_320M) !rst_n |-> (i_valid == '0 && i_free == '0))
		else $error("egress valid or buffer free seen during reset");

	for (genvar g = 0; g < NPORTS; g++) begin : g_port
		// one cycle per freed address
		assert property (@(posedge clk_320M) disable iff (!rst_n) i_free[g] |=> !i_free[g])
			else $error("buffer free pulse on port %0d lasted more than one cycle", g);

		// head stays until popped
		assert property (@(posedge clk_320M) disable iff (!rst_n)
			(i_valid[g] && !i_rd[g]) |=> i_valid[g])
			else $error("egress valid on port %0d dropped without a read", g);
	end

endmodule

`default_nettype wire

//--- tests/gsm_unit_tb.sv
// memory unit testbench
// table of cell bursts checked against per-port reference queues
`default_nettype none

module gsm_unit_tb
	import gsm_pkg::*;
();

	// ------------------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------------------

	localparam logic [1:0] SEL_ONE = 2'd0;
	localparam logic [1:0] SEL_NONE = 2'd1;
	localparam logic [1:0] SEL_TWO = 2'd2;

	typedef struct packed {
		logic [1:0]        port;
		logic [AWIDTH-1:0] addr;
		logic [3:0]        mcast;
		logic [3:0]        en_mask;
		logic [3:0]        hold;
		logic [4:0]        count;
		logic [4:0]        thresh;
		logic [1:0]        sel_mode;
	} test_row_t;

	localparam int NUM_TESTS = 10;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

	// port, first addr, multicast, enable, held reads, cells, threshold, select
	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{2'd0, 7'd5,  4'b0001, 4'hf, 4'h0, 5'd3,  5'd12, SEL_ONE},
		'{2'd1, 7'd10, 4'b0010, 4'hf, 4'h0, 5'd3,  5'd12, SEL_ONE},
		'{2'd2, 7'd20, 4'b0100, 4'hf, 4'h0, 5'd3,  5'd12, SEL_ONE},
		'{2'd3, 7'd30, 4'b1000, 4'hf, 4'h0, 5'd3,  5'd12, SEL_ONE},
		'{2'd2, 7'd40, 4'b1011, 4'hf, 4'h0, 5'd2,  5'd12, SEL_ONE},
		'{2'd1, 7'd50, 4'b0100, 4'hb, 4'h0, 5'd2,  5'd12, SEL_ONE},
		'{2'd3, 7'd60, 4'b0111, 4'hb, 4'h0, 5'd2,  5'd12, SEL_ONE},
		'{2'd0, 7'd70, 4'b0011, 4'hf, 4'h2, 5'd12, 5'd4,  SEL_ONE},
		'{2'd1, 7'd90, 4'b0001, 4'hf, 4'h0, 5'd2,  5'd12, SEL_NONE},
		'{2'd2, 7'd95, 4'b0100, 4'hf, 4'h0, 5'd2,  5'd12, SEL_TWO}
	};

	logic                  clk_320M;
	logic                  rst_n;
	logic                  wr_en [NPORTS];
	logic [AWIDTH-1:0]     wr_addr [NPORTS];
	logic [NPORTS-1:0]     mcast [NPORTS];
	logic                  egress_rd [NPORTS];
	logic                  egress_valid [NPORTS];
	logic [DWIDTH-1:0]     egress_data [NPORTS];
	logic                  buf_free [NPORTS];
	logic [AWIDTH-1:0]     buf_free_addr [NPORTS];
	logic [NPORTS-1:0]     common_sel;
	logic [DWIDTH-1:0]     common_wr_data;
	logic                  cfg_wr;
	cfg_reg_e              cfg_addr;
	logic [CFG_DWIDTH-1:0] cfg_wdata;
	logic [NPORTS-1:0]     hold_mask;
	int                    errors;

	// reference model queues of expected words and freed addresses
	logic [DWIDTH-1:0] exp_egress [NPORTS][$];
	logic [AWIDTH-1:0] exp_free [NPORTS][$];

	gsm_unit uut (
		.clk_320M (clk_320M), .rst_n (rst_n),
		.i_wr_en0 (wr_en[0]), .i_wr_addr0 (wr_addr[0]), .i_multicast0 (mcast[0]),
		.i_wr_en1 (wr_en[1]), .i_wr_addr1 (wr_addr[1]), .i_multicast1 (mcast[1]),
		.i_wr_en2 (wr_en[2]), .i_wr_addr2 (wr_addr[2]), .i_multicast2 (mcast[2]),
		.i_wr_en3 (wr_en[3]), .i_wr_addr3 (wr_addr[3]), .i_multicast3 (mcast[3]),
		.i_egress_rd0 (egress_rd[0]), .o_egress_valid0 (egress_valid[0]),
		.o_egress_data0 (egress_data[0]),
		.i_egress_rd1 (egress_rd[1]), .o_egress_valid1 (egress_valid[1]),
		.o_egress_data1 (egress_data[1]),
		.i_egress_rd2 (egress_rd[2]), .o_egress_valid2 (egress_valid[2]),
		.o_egress_data2 (egress_data[2]),
		.i_egress_rd3 (egress_rd[3]), .o_egress_valid3 (egress_valid[3]),
		.o_egress_data3 (egress_data[3]),
		.o_buf_free0 (buf_free[0]), .o_buf_free_addr0 (buf_free_addr[0]),
		.o_buf_free1 (buf_free[1]), .o_buf_free_addr1 (buf_free_addr[1]),
		.o_buf_free2 (buf_free[2]), .o_buf_free_addr2 (buf_free_addr[2]),
		.o_buf_free3 (buf_free[3]), .o_buf_free_addr3 (buf_free_addr[3]),
		.i_common_sel (common_sel), .i_common_wr_data (common_wr_data),
		.i_cfg_wr (cfg_wr), .i_cfg_addr (cfg_addr), .i_cfg_wdata (cfg_wdata)
	);

	bind gsm_unit gsm_unit_checker unit_checks (
		.clk_320M (clk_320M),
		.rst_n    (rst_n),
		.i_valid  ({o_egress_valid3, o_egress_valid2, o_egress_valid1, o_egress_valid0}),
		.i_rd     ({i_egress_rd3, i_egress_rd2, i_egress_rd1, i_egress_rd0}),
		.i_free   ({o_buf_free3, o_buf_free2, o_buf_free1, o_buf_free0})
	);

	always #5 clk_320M = ~clk_320M;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// step to one unit past the rising edge
	task automatic next_cycle();
		@(posedge clk_320M);
		#1;
	endtask

	task automatic idle_inputs();
		for (int p = 0; p < NPORTS; p++)
			wr_en[p] = 1'b0;
		common_sel = '0;
		// bus idles at zero between cells
		common_wr_data = '0;
		cfg_wr = 1'b0;
	endtask

	task automatic write_cfg(input cfg_reg_e code, input logic [CFG_DWIDTH-1:0] data);
		next_cycle();
		cfg_wr = 1'b1;
		cfg_addr = code;
		cfg_wdata = data;
		next_cycle();
		cfg_wr = 1'b0;
	endtask

	// drive one cell on the common bus
	// only a clean select adds expected results
	task automatic send_cell(input test_row_t row, input int idx);
		logic [DWIDTH-1:0] payload;
		logic [NPORTS-1:0] targets;
		logic [AWIDTH-1:0] addr;
		int                src;
		int                other;
		src = int'(row.port);
		other = (src + 1) % NPORTS;
		addr = row.addr + AWIDTH'(idx);
		payload = {$urandom, $urandom, $urandom, $urandom};
		next_cycle();
		wr_en[src] = 1'b1;
		wr_addr[src] = addr;
		mcast[src] = row.mcast;
		common_wr_data = payload;
		if (row.sel_mode == SEL_ONE) begin
			common_sel = 4'b0001 << src;
			targets = row.mcast & row.en_mask;
			for (int p = 0; p < NPORTS; p++) begin
				if (targets[p])
					exp_egress[p].push_back(payload);
			end
			exp_free[src].push_back(addr);
		end else if (row.sel_mode == SEL_TWO) begin
			// second port also claims the bus
			common_sel = (4'b0001 << src) | (4'b0001 << other);
			wr_en[other] = 1'b1;
			wr_addr[other] = addr;
			mcast[other] = row.mcast;
		end else begin
			// every port asks to write while no port owns the bus
			for (int p = 0; p < NPORTS; p++) begin
				wr_en[p] = 1'b1;
				wr_addr[p] = addr;
				mcast[p] = row.mcast;
			end
			common_sel = '0;
		end
		next_cycle();
		idle_inputs();
	endtask

	function automatic bit all_drained();
		for (int p = 0; p < NPORTS; p++) begin
			if (exp_egress[p].size() != 0 || exp_free[p].size() != 0 || egress_valid[p])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// pop a head word and compare with the model
	task automatic take_word(input int p);
		logic [DWIDTH-1:0] exp;
		egress_rd[p] = 1'b1;
		assert (exp_egress[p].size() > 0) else begin
			$display("egress port %0d gave a word that no cell was sent to, time %0t", p, $time);
			errors++;
		end
		if (exp_egress[p].size() > 0) begin
			exp = exp_egress[p].pop_front();
			assert (egress_data[p] == exp) else begin
				$display("FAILED time %0t o_egress_data%0d expected %h actual %h",
					$time, p, exp, egress_data[p]);
				errors++;
			end
		end
	endtask

	task automatic take_free(input int p);
		logic [AWIDTH-1:0] exp;
		assert (exp_free[p].size() > 0) else begin
			$display("buffer free on port %0d with no cell outstanding, time %0t", p, $time);
			errors++;
		end
		if (exp_free[p].size() > 0) begin
			exp = exp_free[p].pop_front();
			assert (buf_free_addr[p] == exp) else begin
				$display("FAILED time %0t o_buf_free_addr%0d expected %h actual %h",
					$time, p, exp, buf_free_addr[p]);
				errors++;
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// egress reader and free monitor
	// ------------------------------------------------------------------------

	initial begin : read_monitor
		for (int p = 0; p < NPORTS; p++)
			egress_rd[p] = 1'b0;
		forever begin
			next_cycle();
			for (int p = 0; p < NPORTS; p++) begin
				egress_rd[p] = 1'b0;
				if (rst_n && egress_valid[p] && !hold_mask[p])
					take_word(p);
				if (rst_n && buf_free[p])
					take_free(p);
			end
		end
	end

	// hang guard sized from the table length
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_320M);
		$display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin : main_seq
		int unsigned seed_val;
		int          errs_before;
		int          tests_failed;
		int          remaining;
		seed_val = $urandom(35);
		errors = 0;
		tests_failed = 0;
		clk_320M = 1'b0;
		rst_n = 1'b0;
		hold_mask = '0;
		cfg_addr = CFG_EGRESS_EN;
		cfg_wdata = '0;
		common_wr_data = '0;
		for (int p = 0; p < NPORTS; p++) begin
			wr_addr[p] = '0;
			mcast[p] = '0;
		end
		idle_inputs();
		repeat (16) @(posedge clk_320M);
		#1;
		rst_n = 1'b1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			errs_before = errors;
			write_cfg(CFG_EGRESS_EN, {4'h0, TESTS[t].en_mask});
			write_cfg(CFG_AF_THRESH, {3'h0, TESTS[t].thresh});
			hold_mask = TESTS[t].hold;
			for (int i = 0; i < int'(TESTS[t].count); i++)
				send_cell(TESTS[t], i);
			if (TESTS[t].hold != '0) begin
				// held port fills to the threshold while the rest stays pending
				remaining = int'(TESTS[t].count) - int'(TESTS[t].thresh);
				while (exp_free[TESTS[t].port].size() > remaining)
					next_cycle();
				repeat (10) next_cycle();
				assert (exp_free[TESTS[t].port].size() == remaining) else begin
					$display("cells kept leaving while port reads were held, time %0t", $time);
					errors++;
				end
				hold_mask = '0;
			end
			while (!all_drained())
				next_cycle();
			// quiet window for stray outputs
			repeat (20) next_cycle();
			if (errors != errs_before)
				tests_failed++;
			$display("test %0d from port %0d with %0d cells: %s", t, TESTS[t].port,
				TESTS[t].count, (errors == errs_before) ? "ok" : "mismatches");
		end

		$display("%0d tests run, %0d with mismatches, %0d check errors",
			NUM_TESTS, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
logic/gsm_pkg.sv
logic/gsm_sync_fifo.sv
logic/gsm_ingress_mux.sv
logic/gsm_cfg_regs.sv
logic/gsm_central_ram.sv
logic/gsm_unit.sv
tests/gsm_unit_checker.sv
tests/gsm_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module gsm_unit_tb \
	-o gsm_unit_sim > build.log 2>&1 \
	&& ./obj_dir/gsm_unit_sim > "$LOG" 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and $LOG"; exit 1; }

grep -q "Test failures found" "$LOG" \
	&& { echo "simulation reported failures, see $LOG"; exit 1; } \
	|| { echo "simulation clean"; exit 0; }
